// File: src/panel_ctrl_pkg.sv
// shared definitions for the LED panel command front end
// geometry, opcodes, dispatcher states and bus structs

package panel_ctrl_pkg;

    // panel geometry, 32 rows by 64 columns, two bytes per pixel
    localparam int row_bits = 5;
    localparam int col_bits = 6;
    localparam int mem_addr_bits = row_bits + col_bits + 1;
    localparam int mem_depth = 2 ** mem_addr_bits;

    // number of bit-planes in the brightness mask
    localparam int brightness_levels = 6;

    typedef logic [row_bits-1:0] row_addr_t;
    typedef logic [col_bits-1:0] col_addr_t;

    // row, column, byte select
    typedef logic [mem_addr_bits-1:0] mem_addr_t;

    typedef logic [brightness_levels-1:0] brightness_t;

    typedef enum logic [7:0] {
        red_on          = 8'h01,
        red_off         = 8'h02,
        green_on        = 8'h03,
        green_off       = 8'h04,
        blue_on         = 8'h05,
        blue_off        = 8'h06,
        bright_zero     = 8'h10,
        bright_one      = 8'h11,
        bright_two      = 8'h12,
        bright_three    = 8'h13,
        bright_four     = 8'h14,
        bright_five     = 8'h15,
        bright_six      = 8'h16,
        bright_nine     = 8'h19,
        read_brightness = 8'h20,
        read_pixel      = 8'h21,
        blank_panel     = 8'h22
    } opcode_t;

    typedef enum logic [1:0] {
        st_idle,
        st_read_brightness,
        st_read_pixel,
        st_blank_panel
    } ctrl_state_t;

    // one received byte, read as payload or cast to opcode_t
    typedef struct packed {
        logic [7:0] payload;
    } cmd_byte_t;

    typedef struct packed {
        logic       we;
        mem_addr_t  addr;
        logic [7:0] data;
    } mem_write_t;

endpackage

// File: src/cmd_dispatch.sv
// command dispatcher for the LED panel front end
// decodes opcodes, holds colour and brightness, routes argument bytes

`timescale 1ns/1ps

module cmd_dispatch (
    input  logic                        clk_in,
    input  logic                        reset,
    input  panel_ctrl_pkg::cmd_byte_t   cmd,
    input  logic                        cmd_valid,
    output logic                        cmd_ready,
    output logic [2:0]                  rgb_enable,
    output panel_ctrl_pkg::brightness_t brightness,
    output logic                        arg_valid,
    output panel_ctrl_pkg::cmd_byte_t   arg,
    output logic                        blank_start,
    input  logic                        pixel_done,
    input  logic                        blank_done
);

    panel_ctrl_pkg::ctrl_state_t state;
    panel_ctrl_pkg::opcode_t     opcode;
    logic                        xfer;
    logic                        decode;
    logic [2:0]                  plane_sel;

    assign opcode = panel_ctrl_pkg::opcode_t'(cmd.payload);

    // input is held off only during the blank sweep
    assign cmd_ready = (state != panel_ctrl_pkg::st_blank_panel);
    assign xfer = cmd_valid && cmd_ready;

    // a new opcode may follow in the same cycle the pixel writer finishes
    assign decode = xfer && ((state == panel_ctrl_pkg::st_idle) ||
                    (state == panel_ctrl_pkg::st_read_pixel && pixel_done));

    assign arg_valid = xfer && (state == panel_ctrl_pkg::st_read_pixel) && !pixel_done;
    assign arg = cmd;

    assign blank_start = decode && (opcode == panel_ctrl_pkg::blank_panel);

    // bright_one hits the top plane, bright_six the lowest
    assign plane_sel = 3'(panel_ctrl_pkg::brightness_levels) - cmd.payload[2:0];

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= panel_ctrl_pkg::st_idle;
            rgb_enable <= 3'b111;
            brightness <= '1;
        end else begin
            case (state)
                panel_ctrl_pkg::st_read_brightness: begin
                    if (xfer) begin
                        brightness <= cmd.payload[panel_ctrl_pkg::brightness_levels-1:0];
                        state <= panel_ctrl_pkg::st_idle;
                    end
                end
                panel_ctrl_pkg::st_read_pixel: begin
                    if (pixel_done) begin
                        state <= panel_ctrl_pkg::st_idle;
                    end
                end
                panel_ctrl_pkg::st_blank_panel: begin
                    if (blank_done) begin
                        state <= panel_ctrl_pkg::st_idle;
                    end
                end
                default: begin
                end
            endcase

            if (decode) begin
                case (opcode)
                    panel_ctrl_pkg::red_on:    rgb_enable[0] <= 1'b1;
                    panel_ctrl_pkg::red_off:   rgb_enable[0] <= 1'b0;
                    panel_ctrl_pkg::green_on:  rgb_enable[1] <= 1'b1;
                    panel_ctrl_pkg::green_off: rgb_enable[1] <= 1'b0;
                    panel_ctrl_pkg::blue_on:   rgb_enable[2] <= 1'b1;
                    panel_ctrl_pkg::blue_off:  rgb_enable[2] <= 1'b0;
                    panel_ctrl_pkg::bright_zero: begin
                        brightness <= '0;
                    end
                    panel_ctrl_pkg::bright_nine: begin
                        brightness <= '1;
                    end
                    panel_ctrl_pkg::bright_one, panel_ctrl_pkg::bright_two,
                    panel_ctrl_pkg::bright_three, panel_ctrl_pkg::bright_four,
                    panel_ctrl_pkg::bright_five, panel_ctrl_pkg::bright_six: begin
                        brightness[plane_sel] <= ~brightness[plane_sel];
                    end
                    panel_ctrl_pkg::read_brightness: begin
                        state <= panel_ctrl_pkg::st_read_brightness;
                    end
                    panel_ctrl_pkg::read_pixel: begin
                        state <= panel_ctrl_pkg::st_read_pixel;
                    end
                    panel_ctrl_pkg::blank_panel: begin
                        state <= panel_ctrl_pkg::st_blank_panel;
                    end
                    // unknown opcodes are dropped
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

// File: src/pixel_writer.sv
// read-pixel handler
// gathers row, column and two data bytes, then writes both bytes to frame memory

`timescale 1ns/1ps

module pixel_writer (
    input  logic                       clk_in,
    input  logic                       reset,
    input  logic                       arg_valid,
    input  panel_ctrl_pkg::cmd_byte_t  arg,
    output panel_ctrl_pkg::mem_write_t mem_wr,
    output logic                       done
);

    // argument index: row, column, first byte, second byte
    logic [1:0]                arg_count;
    panel_ctrl_pkg::row_addr_t row;
    panel_ctrl_pkg::col_addr_t col;
    logic                      data_arg;

    assign data_arg = arg_valid && arg_count[1];

    always_ff @(posedge clk_in) begin
        if (reset) begin
            arg_count <= 2'd0;
        end else if (arg_valid) begin
            arg_count <= arg_count + 2'd1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (arg_valid && arg_count == 2'd0) begin
            row <= arg.payload[panel_ctrl_pkg::row_bits-1:0];
        end
        if (arg_valid && arg_count == 2'd1) begin
            col <= arg.payload[panel_ctrl_pkg::col_bits-1:0];
        end
    end

    // first data byte lands at byte select 1, the second at 0
    always_ff @(posedge clk_in) begin
        if (reset) begin
            mem_wr <= '0;
            done <= 1'b0;
        end else begin
            mem_wr <= '0;
            done <= 1'b0;
            if (data_arg) begin
                mem_wr.we <= 1'b1;
                mem_wr.addr <= {row, col, ~arg_count[0]};
                mem_wr.data <= arg.payload;
                done <= arg_count[0];
            end
        end
    end

endmodule

// File: src/panel_blanker.sv
// blank-panel handler
// sweeps every frame-memory byte once, writing zero

`timescale 1ns/1ps

module panel_blanker (
    input  logic                       clk_in,
    input  logic                       reset,
    input  logic                       start,
    output panel_ctrl_pkg::mem_write_t mem_wr,
    output logic                       done
);

    logic                      busy;
    panel_ctrl_pkg::mem_addr_t addr;
    logic                      last;

    assign last = (addr == panel_ctrl_pkg::mem_addr_t'(panel_ctrl_pkg::mem_depth - 1));

    // counter wraps back to zero after the last byte
    always_ff @(posedge clk_in) begin
        if (reset) begin
            busy <= 1'b0;
            addr <= '0;
        end else if (busy) begin
            addr <= addr + panel_ctrl_pkg::mem_addr_t'(1);
            if (last) begin
                busy <= 1'b0;
            end
        end else if (start) begin
            busy <= 1'b1;
            addr <= '0;
        end
    end

    always_comb begin
        mem_wr = '0;
        mem_wr.we = busy;
        mem_wr.addr = busy ? addr : '0;
    end

    assign done = busy && last;

endmodule

// File: src/panel_ctrl_top.sv
// LED panel command front end
// byte commands in, colour and brightness state and frame-memory writes out

`timescale 1ns/1ps

module panel_ctrl_top (
    input  logic                        clk_in,
    input  logic                        reset,
    input  panel_ctrl_pkg::cmd_byte_t   cmd,
    input  logic                        cmd_valid,
    output logic                        cmd_ready,
    output logic [2:0]                  rgb_enable,
    output panel_ctrl_pkg::brightness_t brightness,
    output panel_ctrl_pkg::mem_write_t  mem_wr
);

    logic                       arg_valid;
    panel_ctrl_pkg::cmd_byte_t  arg;
    logic                       blank_start;
    logic                       pixel_done;
    logic                       blank_done;
    panel_ctrl_pkg::mem_write_t pixel_wr;
    panel_ctrl_pkg::mem_write_t blank_wr;

    cmd_dispatch u_dispatch (
        .clk_in      (clk_in),
        .reset       (reset),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .rgb_enable  (rgb_enable),
        .brightness  (brightness),
        .arg_valid   (arg_valid),
        .arg         (arg),
        .blank_start (blank_start),
        .pixel_done  (pixel_done),
        .blank_done  (blank_done)
    );

    pixel_writer u_pixel_writer (
        .clk_in    (clk_in),
        .reset     (reset),
        .arg_valid (arg_valid),
        .arg       (arg),
        .mem_wr    (pixel_wr),
        .done      (pixel_done)
    );

    panel_blanker u_blanker (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (blank_start),
        .mem_wr (blank_wr),
        .done   (blank_done)
    );

    // idle handler drives all zero, so OR is enough
    assign mem_wr = panel_ctrl_pkg::mem_write_t'(pixel_wr | blank_wr);

endmodule

// File: include/panel_ref_model.svh
// reference model for the panel command front end testbench
// expected colour and brightness, frame memory update, random source

`ifndef PANEL_REF_MODEL_SVH
`define PANEL_REF_MODEL_SVH

function automatic logic [2:0] ref_rgb(input logic [2:0] cur,
                                       input panel_ctrl_pkg::opcode_t op);
    logic [2:0] nxt;
    nxt = cur;
    case (op)
        panel_ctrl_pkg::red_on:    nxt[0] = 1'b1;
        panel_ctrl_pkg::red_off:   nxt[0] = 1'b0;
        panel_ctrl_pkg::green_on:  nxt[1] = 1'b1;
        panel_ctrl_pkg::green_off: nxt[1] = 1'b0;
        panel_ctrl_pkg::blue_on:   nxt[2] = 1'b1;
        panel_ctrl_pkg::blue_off:  nxt[2] = 1'b0;
        default: nxt = cur;
    endcase
    return nxt;
endfunction

// bright_one..bright_six toggle plane levels-n
function automatic panel_ctrl_pkg::brightness_t ref_brightness(
    input panel_ctrl_pkg::brightness_t cur, input logic [7:0] op);
    panel_ctrl_pkg::brightness_t nxt;
    nxt = cur;
    if (op == 8'h10) begin
        nxt = '0;
    end else if (op == 8'h19) begin
        nxt = '1;
    end else if (op >= 8'h11 && op <= 8'h16) begin
        nxt[panel_ctrl_pkg::brightness_levels - int'(op[2:0])] ^= 1'b1;
    end
    return nxt;
endfunction

function automatic void ref_mem_apply(ref logic [7:0] mem [panel_ctrl_pkg::mem_depth],
                                      input panel_ctrl_pkg::mem_write_t wr);
    if (wr.we) begin
        mem[wr.addr] = wr.data;
    end
endfunction

// galois form, one step per random bit
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

`endif

// File: verification/tb_panel_ctrl.sv
// testbench for the LED panel command front end
// random command streams checked against a reference model and a frame-memory model

`timescale 1ns/1ps

module tb_panel_ctrl;

    localparam int clk_period = 40;
    localparam logic [31:0] seed = 32'heca74072;
    localparam int n_colour = 40;
    localparam int n_bright = 40;
    localparam int n_pixel = 20;
    localparam int n_unknown = 30;
    localparam int n_tests = 6;
    localparam int sweep_cycles = panel_ctrl_pkg::mem_depth;
    localparam int timeout_cycles = n_tests * sweep_cycles + 2000;

    logic                        clk_in;
    logic                        reset;
    panel_ctrl_pkg::cmd_byte_t   cmd;
    logic                        cmd_valid;
    logic                        cmd_ready;
    logic [2:0]                  rgb_enable;
    panel_ctrl_pkg::brightness_t brightness;
    panel_ctrl_pkg::mem_write_t  mem_wr;

    logic [31:0]                 lfsr = seed;
    logic [2:0]                  exp_rgb;
    panel_ctrl_pkg::brightness_t exp_bright;
    logic [7:0]                  mem_seen [panel_ctrl_pkg::mem_depth];
    logic [7:0]                  mem_exp [panel_ctrl_pkg::mem_depth];
    panel_ctrl_pkg::mem_write_t  exp_wr [$];
    logic                        exp_ready [$];
    int                          write_count = 0;

    `include "panel_ref_model.svh"

    panel_ctrl_top u_panel_ctrl_top (
        .clk_in     (clk_in),
        .reset      (reset),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .rgb_enable (rgb_enable),
        .brightness (brightness),
        .mem_wr     (mem_wr)
    );

    initial clk_in = 1'b0;
    always #(clk_period / 2) clk_in = ~clk_in;

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic known_opcode(input logic [7:0] op);
        return (op >= 8'h01 && op <= 8'h06) || (op >= 8'h10 && op <= 8'h16) ||
               (op == 8'h19) || (op >= 8'h20 && op <= 8'h22);
    endfunction

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    // random idle gap, then hold the byte until it transfers
    task automatic send_byte(input logic [7:0] b);
        int gap;
        gap = int'(take_bits(2));
        repeat (gap) @(posedge clk_in);
        cmd <= panel_ctrl_pkg::cmd_byte_t'(b);
        cmd_valid <= 1'b1;
        @(posedge clk_in);
        while (!cmd_ready) @(posedge clk_in);
        cmd_valid <= 1'b0;
    endtask

    task automatic check_state();
        @(posedge clk_in);
        compare_value("rgb_enable", 32'(exp_rgb), 32'(rgb_enable));
        compare_value("brightness", 32'(exp_bright), 32'(brightness));
    endtask

    task automatic wait_writes();
        while (exp_wr.size() != 0) @(posedge clk_in);
    endtask

    task automatic compare_memory();
        for (int a = 0; a < panel_ctrl_pkg::mem_depth; a++) begin
            compare_value($sformatf("frame byte %0d", a),
                          32'(mem_exp[panel_ctrl_pkg::mem_addr_t'(a)]),
                          32'(mem_seen[panel_ctrl_pkg::mem_addr_t'(a)]));
        end
    endtask

    task automatic expect_write(input panel_ctrl_pkg::mem_addr_t addr, input logic [7:0] data,
                                input logic ready);
        panel_ctrl_pkg::mem_write_t w;
        w.we = 1'b1;
        w.addr = addr;
        w.data = data;
        exp_wr.push_back(w);
        exp_ready.push_back(ready);
        mem_exp[addr] = data;
    endtask

    // first data byte goes to byte select 1
    task automatic pixel_command();
        logic [7:0] row;
        logic [7:0] col;
        logic [7:0] d1;
        logic [7:0] d2;
        row = 8'(take_bits(8));
        col = 8'(take_bits(8));
        d1 = 8'(take_bits(8));
        d2 = 8'(take_bits(8));
        expect_write({row[panel_ctrl_pkg::row_bits-1:0], col[panel_ctrl_pkg::col_bits-1:0], 1'b1},
                     d1, 1'b1);
        expect_write({row[panel_ctrl_pkg::row_bits-1:0], col[panel_ctrl_pkg::col_bits-1:0], 1'b0},
                     d2, 1'b1);
        send_byte(8'h21);
        send_byte(row);
        send_byte(col);
        send_byte(d1);
        send_byte(d2);
        wait_writes();
        compare_memory();
    endtask

    // every write must match the next expected one
    always @(posedge clk_in) begin
        panel_ctrl_pkg::mem_write_t exp;
        logic                       rdy;
        if (!reset && mem_wr.we) begin
            if (exp_wr.size() == 0) begin
                report_problem("a frame-memory write appeared when none was expected");
            end else begin
                exp = exp_wr.pop_front();
                rdy = exp_ready.pop_front();
                compare_value("mem_wr.addr", 32'(exp.addr), 32'(mem_wr.addr));
                compare_value("mem_wr.data", 32'(exp.data), 32'(mem_wr.data));
                compare_value("cmd_ready", 32'(rdy), 32'(cmd_ready));
                ref_mem_apply(mem_seen, mem_wr);
                write_count++;
            end
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk_in);
        report_problem("watchdog expired before the tests finished");
    end

    initial begin
        logic [7:0] op;
        logic [7:0] arg;
        int         sel;
        int         count0;
        int         low_cycles;
        reset = 1'b1;
        cmd = '0;
        cmd_valid = 1'b0;
        exp_rgb = 3'b111;
        exp_bright = '1;
        // prior frame RAM contents
        for (int a = 0; a < panel_ctrl_pkg::mem_depth; a++) begin
            mem_seen[a] = 8'(a ^ (a >> 4));
            mem_exp[a] = 8'(a ^ (a >> 4));
        end
        repeat (4) @(posedge clk_in);
        reset <= 1'b0;
        check_state();
        compare_value("cmd_ready", 32'(1), 32'(cmd_ready));

        for (int i = 0; i < n_colour; i++) begin
            op = 8'(take_bits(8) % 6) + 8'h01;
            send_byte(op);
            exp_rgb = ref_rgb(exp_rgb, panel_ctrl_pkg::opcode_t'(op));
            check_state();
        end

        for (int i = 0; i < n_bright; i++) begin
            sel = int'(take_bits(3));
            if (sel == 0) begin
                op = 8'h10;
            end else if (sel == 1) begin
                op = 8'h19;
            end else if (sel == 2) begin
                op = 8'h20;
            end else begin
                op = 8'(take_bits(8) % 6) + 8'h11;
            end
            send_byte(op);
            if (op == 8'h20) begin
                arg = 8'(take_bits(8));
                send_byte(arg);
                exp_bright = arg[panel_ctrl_pkg::brightness_levels-1:0];
            end else begin
                exp_bright = ref_brightness(exp_bright, op);
            end
            check_state();
        end

        for (int i = 0; i < n_pixel; i++) begin
            pixel_command();
        end

        // zero sweep over the whole address space
        for (int a = 0; a < panel_ctrl_pkg::mem_depth; a++) begin
            expect_write(panel_ctrl_pkg::mem_addr_t'(a), 8'h00, 1'b0);
        end
        count0 = write_count;
        send_byte(8'h22);
        // ready stays low from the cycle after the opcode through the done cycle
        low_cycles = 0;
        @(posedge clk_in);
        while (!cmd_ready) begin
            low_cycles++;
            @(posedge clk_in);
        end
        compare_value("cmd_ready low cycles", 32'(sweep_cycles), 32'(low_cycles));
        compare_value("blank write count", 32'(sweep_cycles), 32'(write_count - count0));
        compare_memory();

        for (int i = 0; i < n_unknown; i++) begin
            op = 8'(take_bits(8));
            while (known_opcode(op)) op = 8'(take_bits(8));
            send_byte(op);
            check_state();
        end

        repeat (2) @(posedge clk_in);
        if (exp_wr.size() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            report_problem("expected frame-memory writes never appeared");
        end
    end

endmodule

// File: verilog.f
+incdir+include
src/panel_ctrl_pkg.sv
src/cmd_dispatch.sv
src/pixel_writer.sv
src/panel_blanker.sv
src/panel_ctrl_top.sv
verification/tb_panel_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# build and run the panel front end testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --top-module tb_panel_ctrl -f verilog.f
# the log decides pass or fail
./obj_dir/Vtb_panel_ctrl > sim.log 2>&1 || true
cat sim.log
if grep -q "Test failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
